/* verilog.f */
verilog/rrq_cfg_pkg.sv
verilog/rrq_types_pkg.sv
verilog/port_queue.sv
verilog/rr_arbiter.sv
verilog/egress_stage.sv
verilog/rr_queue_mux.sv
dv/tb_rr_queue_mux.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run the testbench and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_rr_queue_mux -f verilog.f \
    && ./obj_dir/Vtb_rr_queue_mux | tee sim.log
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* dv/tb_rr_queue_mux.sv */
`timescale 1ns/10ps

module tb_rr_queue_mux;

    localparam int NP          = rrq_cfg_pkg::NUM_PORTS;
    localparam int DEPTH       = rrq_cfg_pkg::QUEUE_DEPTH;
    localparam int RANDOM_CYC  = 400;
    localparam int DRAIN_LIMIT = 300;
    localparam int WAIT_LIMIT  = 60;
    localparam int BUDGET_CYC  = 30 + RANDOM_CYC + 3 * DRAIN_LIMIT + 6 * WAIT_LIMIT + 120;
    localparam int WATCHDOG_NS = BUDGET_CYC * 20 + 2000;

    logic                      clk;
    logic                      rst_n;
    rrq_types_pkg::port_mask_t in_valid;
    rrq_types_pkg::port_data_t in_data;
    rrq_types_pkg::port_mask_t credit_return;
    logic                      out_credit;
    logic                      out_valid;
    rrq_types_pkg::data_t      out_data;
    rrq_types_pkg::port_idx_t  out_port;
    rrq_types_pkg::port_mask_t err;

    rrq_types_pkg::data_t     model_q [NP][$];  // bytes pushed and not yet seen at the output.
    int                       src_credit [NP];
    int                       ret_cnt [NP];
    int                       out_cnt [NP];
    int                       rx_owed;  // credits the receiver still has to hand back.
    int                       total_out;
    int                       check_cnt;
    int                       error_cnt;
    int                       tests_run;
    int                       tests_failed;
    logic [31:0]              lcg_state;
    logic                     rr_check;
    logic                     rr_prev_ok;
    rrq_types_pkg::port_idx_t rr_prev;

    rr_queue_mux DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .credit_return (credit_return),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_port      (out_port),
        .err           (err)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ******************************************************************
    // helpers
    // ******************************************************************

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit any_pending();
        bit busy;
        busy = 1'b0;
        for (int p = 0; p < NP; p++) begin
            if (model_q[p].size() != 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        check_cnt++;
        if (got !== expected) begin
            error_cnt++;
            $display("error at %0t ns: %s, expected %0h, got %0h", $time, what, expected, got);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int errors;
        errors = error_cnt - errors_before;
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test %0d, %s: %s with %0d errors", tests_run, name,
                 (errors == 0) ? "ok" : "failed", errors);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n      <= 1'b0;
        in_valid   <= '0;
        out_credit <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < NP; p++) begin
            model_q[p].delete();
            src_credit[p] = DEPTH;
            ret_cnt[p]    = 0;
            out_cnt[p]    = 0;
        end
        rx_owed = 0;
    endtask

    // one clock of stimulus; the model takes each pushed byte as it is driven.
    task automatic drive_cycle(input rrq_types_pkg::port_mask_t push, input logic credit);
        rrq_types_pkg::port_data_t bytes;
        for (int p = 0; p < NP; p++) begin
            bytes[p] = rrq_types_pkg::data_t'(next_rand() >> 16);
        end
        @(posedge clk);
        for (int p = 0; p < NP; p++) begin
            if (push[p]) begin
                model_q[p].push_back(bytes[p]);
                src_credit[p] = src_credit[p] - 1;
            end
        end
        if (credit && rx_owed > 0) begin
            rx_owed = rx_owed - 1;  // a credit beyond those owed finds the counter full.
        end
        in_valid   <= push;
        in_data    <= bytes;
        out_credit <= credit;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle('0, 1'b0);
    endtask

    task automatic random_traffic(input int cycles);
        rrq_types_pkg::port_mask_t push;
        logic [31:0]               r;
        logic                      credit;
        repeat (cycles) begin
            r = next_rand();
            for (int p = 0; p < NP; p++) begin
                push[p] = r[20 + p] && (src_credit[p] > 0);  // a source pushes only on credit.
            end
            credit = r[27] && (rx_owed > 0);
            drive_cycle(push, credit);
        end
    endtask

    // the full queue drops this byte, so it never enters the model.
    task automatic push_without_credit(input int p);
        @(posedge clk);
        in_valid   <= rrq_types_pkg::port_mask_t'(1 << p);
        in_data    <= {NP{8'ha5}};
        out_credit <= 1'b0;
    endtask

    task automatic wait_outputs(input int target, input string what);
        int cycles;
        cycles = 0;
        while (total_out < target && cycles < WAIT_LIMIT) begin
            drive_cycle('0, 1'b0);
            cycles++;
        end
        if (total_out < target) begin
            error_cnt++;
            $display("timed out after %0d cycles waiting for output: %s", WAIT_LIMIT, what);
        end
    endtask

    task automatic drain_all(input string what);
        int cycles;
        cycles = 0;
        while ((any_pending() || rx_owed > 0) && cycles < DRAIN_LIMIT) begin
            drive_cycle('0, rx_owed > 0);
            cycles++;
        end
        if (any_pending() || rx_owed > 0) begin
            error_cnt++;
            $display("queues did not drain within %0d cycles during %s", DRAIN_LIMIT, what);
        end
        idle(4);
    endtask

    // ******************************************************************
    // output monitor
    // ******************************************************************

    always @(negedge clk) begin : monitor
        logic all_busy;
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (credit_return[p]) begin
                    src_credit[p] = src_credit[p] + 1;
                    ret_cnt[p]++;
                end
            end
            if (out_valid) begin
                all_busy = 1'b1;
                for (int p = 0; p < NP; p++) begin
                    if (model_q[p].size() == 0) begin
                        all_busy = 1'b0;
                    end
                end
                if (rr_check && rr_prev_ok && all_busy) begin
                    check_value(32'(out_port), 32'(rrq_types_pkg::port_idx_t'(rr_prev + 1'b1)),
                                "round-robin port order");
                end
                if (rr_check) begin
                    rr_prev    = out_port;
                    rr_prev_ok = 1'b1;
                end
                if (model_q[out_port].size() == 0) begin
                    error_cnt++;
                    $display("byte %0h came out on port %0d with no byte pending there",
                             out_data, out_port);
                end else begin
                    check_value(32'(out_data), 32'(model_q[out_port][0]), "output byte");
                    void'(model_q[out_port].pop_front());
                end
                out_cnt[out_port]++;
                total_out++;
                rx_owed++;
            end
        end
    end

    // ******************************************************************
    // watchdog
    // ******************************************************************

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // ******************************************************************
    // test sequence
    // ******************************************************************

    initial begin
        int               mark;
        int               start;
        int               target;
        int               other;
        int               snap;
        logic [31:0]      r;
        lcg_state    = 32'h7f39;
        rst_n        = 1'b0;
        in_valid     = '0;
        in_data      = '0;
        out_credit   = 1'b0;
        total_out    = 0;
        check_cnt    = 0;
        error_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        rr_check     = 1'b0;
        rr_prev_ok   = 1'b0;
        rr_prev      = '0;
        apply_reset();

        mark = error_cnt;
        repeat (30) begin
            r = next_rand();
            drive_cycle('0, r[31]);
            @(negedge clk);
            check_value(32'(out_valid), 32'd0, "out_valid while idle");
            check_value(32'(credit_return), 32'd0, "credit_return while idle");
            check_value(32'(err), 32'd0, "err after reset");
        end
        finish_test("reset state", mark);

        mark = error_cnt;
        random_traffic(RANDOM_CYC);
        drain_all("random traffic");
        for (int p = 0; p < NP; p++) begin
            check_value(src_credit[p], DEPTH, "source credits after random traffic");
        end
        check_value(32'(err), 32'd0, "err after random traffic");
        finish_test("random traffic integrity", mark);

        mark  = error_cnt;
        start = total_out;
        drive_cycle('1, 1'b0);
        drive_cycle('1, 1'b0);
        wait_outputs(start + rrq_cfg_pkg::OUT_CREDITS, "first egress credits");
        idle(12);
        check_value(total_out - start, rrq_cfg_pkg::OUT_CREDITS, "bytes out without returns");
        for (int k = 1; k <= rrq_cfg_pkg::OUT_CREDITS; k++) begin
            drive_cycle('0, 1'b1);
            wait_outputs(start + rrq_cfg_pkg::OUT_CREDITS + k, "byte released by one credit");
            idle(8);
            check_value(total_out - start, rrq_cfg_pkg::OUT_CREDITS + k, "bytes per returned credit");
        end
        finish_test("egress credit limit", mark);

        mark  = error_cnt;
        start = total_out;
        repeat (DEPTH) drive_cycle('1, 1'b0);  // receiver still holds every egress credit.
        idle(4);
        for (int p = 0; p < NP; p++) begin
            check_value(src_credit[p], 0, "source credits with full queues");
            check_value(ret_cnt[p], out_cnt[p], "credit returns while stalled");
        end
        check_value(total_out - start, 0, "bytes out with no egress credit");
        check_value(32'(err), 32'd0, "err with exactly full queues");
        rr_prev_ok = 1'b0;
        rr_check   = 1'b1;
        drain_all("round-robin drain");
        rr_check = 1'b0;
        check_value(total_out - start, NP * DEPTH, "bytes out after round-robin drain");
        finish_test("round-robin order", mark);

        mark = error_cnt;
        for (int p = 0; p < NP; p++) begin
            check_value(ret_cnt[p], out_cnt[p], "credit returns against bytes out");
            check_value(src_credit[p], DEPTH, "source credits after drain");
        end
        finish_test("ingress credit return", mark);

        mark   = error_cnt;
        r      = next_rand();
        target = int'(r >> 30);
        other  = (target + 1) % NP;
        start  = total_out;
        repeat (rrq_cfg_pkg::OUT_CREDITS) drive_cycle(rrq_types_pkg::port_mask_t'(1 << other), 1'b0);
        wait_outputs(start + rrq_cfg_pkg::OUT_CREDITS, "egress credits to run out");
        snap = out_cnt[target];
        repeat (DEPTH) drive_cycle(rrq_types_pkg::port_mask_t'(1 << target), 1'b0);
        idle(3);
        check_value(32'(err), 32'd0, "err before overflow");
        push_without_credit(target);
        idle(3);
        check_value(32'(err), 1 << target, "err after overflow");
        drain_all("overflow drain");
        check_value(out_cnt[target] - snap, DEPTH, "bytes out of the overflowed port");
        check_value(32'(err), 1 << target, "err held after drain");
        apply_reset();
        @(negedge clk);
        check_value(32'(err), 32'd0, "err after the next reset");
        finish_test("overflow", mark);

        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/rr_queue_mux.sv */
`timescale 1ns/10ps

module rr_queue_mux (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rrq_types_pkg::port_mask_t in_valid,
    input  rrq_types_pkg::port_data_t in_data,
    output rrq_types_pkg::port_mask_t credit_return,
    input  logic                      out_credit,
    output logic                      out_valid,
    output rrq_types_pkg::data_t      out_data,
    output rrq_types_pkg::port_idx_t  out_port,
    output rrq_types_pkg::port_mask_t err
);

    rrq_types_pkg::port_mask_t request;
    rrq_types_pkg::port_mask_t grant;
    rrq_types_pkg::port_idx_t  grant_idx;
    rrq_types_pkg::port_data_t head_data;
    logic                      credit_ok;
    logic                      granted;

    // ******************************************************************
    // ingress queues
    // ******************************************************************

    for (genvar g = 0; g < rrq_cfg_pkg::NUM_PORTS; g++) begin : g_queue
        port_queue u_port_queue (
            .clk           (clk),
            .rst_n         (rst_n),
            .push          (in_valid[g]),
            .push_data     (in_data[g]),
            .pop           (grant[g]),
            .head_data     (head_data[g]),
            .not_empty     (request[g]),
            .credit_return (credit_return[g]),
            .overflow      (err[g])
        );
    end

    // ******************************************************************
    // arbitration
    // ******************************************************************

    rr_arbiter u_rr_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .request   (request),
        .credit_ok (credit_ok),
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    assign granted = |grant;  // the grant is one-hot, so this marks a single pop.

    // ******************************************************************
    // egress
    // ******************************************************************

    egress_stage u_egress_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .granted    (granted),
        .grant_idx  (grant_idx),
        .head_data  (head_data),
        .out_credit (out_credit),
        .credit_ok  (credit_ok),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_port   (out_port)
    );

endmodule

/* verilog/egress_stage.sv */
`timescale 1ns/10ps

module egress_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      granted,
    input  rrq_types_pkg::port_idx_t  grant_idx,
    input  rrq_types_pkg::port_data_t head_data,
    input  logic                      out_credit,
    output logic                      credit_ok,
    output logic                      out_valid,
    output rrq_types_pkg::data_t      out_data,
    output rrq_types_pkg::port_idx_t  out_port
);

    // ******************************************************************
    // egress credit counter
    // ******************************************************************

    rrq_types_pkg::out_credit_t credit_cnt;
    logic                       credit_full;

    assign credit_full = (credit_cnt == rrq_types_pkg::out_credit_t'(rrq_cfg_pkg::OUT_CREDITS));
    assign credit_ok   = (credit_cnt != '0);

    // a grant takes its credit at once, so bytes still in flight are counted.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= rrq_types_pkg::out_credit_t'(rrq_cfg_pkg::OUT_CREDITS);
        end else begin
            case ({granted, out_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: begin
                    if (!credit_full) begin
                        credit_cnt <= credit_cnt + 1'b1;  // a surplus return is ignored.
                    end
                end
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ******************************************************************
    // grant alignment
    // ******************************************************************

    logic                     sel_valid;
    rrq_types_pkg::port_idx_t sel_idx;

    // the popped byte reaches the queue head one cycle after the grant.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= granted;
        end
    end

    always_ff @(posedge clk) begin
        if (granted) begin
            sel_idx <= grant_idx;
        end
    end

    // ******************************************************************
    // output register
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sel_valid;  // one pulse per byte.
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            out_data <= head_data[sel_idx];
            out_port <= sel_idx;
        end
    end

endmodule

/* verilog/rr_arbiter.sv */
`timescale 1ns/10ps

module rr_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rrq_types_pkg::port_mask_t request,
    input  logic                      credit_ok,
    output rrq_types_pkg::port_mask_t grant,
    output rrq_types_pkg::port_idx_t  grant_idx
);

    // ******************************************************************
    // round-robin search
    // ******************************************************************

    rrq_types_pkg::port_idx_t last_grant;
    rrq_types_pkg::port_idx_t pick_idx;
    logic                     pick_found;
    logic                     grant_valid;

    // the search starts one past the last granted port and wraps, so the
    // last granted port itself is checked last.
    always_comb begin
        rrq_types_pkg::port_idx_t cand;
        pick_found = 1'b0;
        pick_idx   = last_grant;
        cand       = last_grant;
        for (int i = 1; i <= rrq_cfg_pkg::NUM_PORTS; i++) begin
            cand = last_grant + rrq_types_pkg::port_idx_t'(i);
            if (!pick_found && request[cand]) begin
                pick_found = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    assign grant_valid = pick_found && credit_ok;  // no grant without an egress credit.

    // ******************************************************************
    // grant outputs
    // ******************************************************************

    always_comb begin
        grant = '0;
        if (grant_valid) begin
            grant[pick_idx] = 1'b1;
        end
    end

    assign grant_idx = pick_idx;  // only meaningful while a grant bit is set.

    // ******************************************************************
    // last-grant pointer
    // ******************************************************************

    // port 3 after reset gives port 0 the first turn.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= rrq_types_pkg::port_idx_t'(rrq_cfg_pkg::NUM_PORTS - 1);
        end else if (grant_valid) begin
            last_grant <= pick_idx;
        end
    end

endmodule

/* verilog/port_queue.sv */
`timescale 1ns/10ps

module port_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  rrq_types_pkg::data_t push_data,
    input  logic                 pop,
    output rrq_types_pkg::data_t head_data,
    output logic                 not_empty,
    output logic                 credit_return,
    output logic                 overflow
);

    // ******************************************************************
    // storage and pointers
    // ******************************************************************

    rrq_types_pkg::data_t            mem [rrq_cfg_pkg::QUEUE_DEPTH];
    logic [rrq_cfg_pkg::PTR_W-1:0]   wr_ptr;
    logic [rrq_cfg_pkg::PTR_W-1:0]   rd_ptr;
    rrq_types_pkg::queue_cnt_t       count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full      = (count == rrq_types_pkg::queue_cnt_t'(rrq_cfg_pkg::QUEUE_DEPTH));
    assign not_empty = (count != '0);

    assign wr_en = push && !full;     // a write into a full queue is dropped.
    assign rd_en = pop && not_empty;  // the arbiter only pops a non-empty queue.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, so the pointer wraps.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // a push and a pop in the same cycle leave the occupancy as it was.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ******************************************************************
    // head register and credit return
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (rd_en) begin
            head_data <= mem[rd_ptr];  // valid in the cycle after the grant.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= rd_en;  // one pulse per popped byte.
        end
    end

    // the flag stays up until reset so that a lost byte is never missed.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

/* verilog/rrq_types_pkg.sv */
package rrq_types_pkg;

    // ******************************************************************
    // payload types
    // ******************************************************************

    typedef logic [rrq_cfg_pkg::DATA_W-1:0] data_t;  // one payload byte.

    // the four ingress bytes side by side, port 0 in the low byte.
    typedef data_t [rrq_cfg_pkg::NUM_PORTS-1:0] port_data_t;

    // ******************************************************************
    // port types
    // ******************************************************************

    typedef logic [$clog2(rrq_cfg_pkg::NUM_PORTS)-1:0] port_idx_t;  // port number.
    typedef logic [rrq_cfg_pkg::NUM_PORTS-1:0] port_mask_t;  // one bit per port.

    // ******************************************************************
    // counter types
    // ******************************************************************

    typedef logic [rrq_cfg_pkg::CNT_W-1:0] queue_cnt_t;  // bytes held in one queue.
    typedef logic [rrq_cfg_pkg::OUT_CREDIT_W-1:0] out_credit_t;  // egress credits left.

endpackage

/* verilog/rrq_cfg_pkg.sv */
package rrq_cfg_pkg;

    // ******************************************************************
    // port and payload sizing
    // ******************************************************************

    localparam int NUM_PORTS    = 4;  // ingress ports, indexed by two bits.
    localparam int DATA_W       = 8;  // one byte per transfer.

    // ******************************************************************
    // queue sizing
    // ******************************************************************

    localparam int QUEUE_DEPTH  = 8;  // also the starting credit count of each source.
    localparam int PTR_W        = 3;  // read and write pointers wrap at the depth.
    localparam int CNT_W        = 4;  // occupancy runs from 0 to QUEUE_DEPTH.

    // ******************************************************************
    // egress credit sizing
    // ******************************************************************

    localparam int OUT_CREDITS  = 4;  // slots the downstream receiver offers after reset.
    localparam int OUT_CREDIT_W = 3;  // counter runs from 0 to OUT_CREDITS.

endpackage
